// File: Bender.yml
package:
  name: branch_rs

dependencies: {}

sources:
  - files:
      - common/brs_pkg.sv
      - logic/brs_slot.sv
      - logic/brs_ctrl.sv
      - logic/brs_drain.sv
      - logic/branch_rs.sv
  - target: simulation
    files:
      - bench/branch_rs_checker.sv
      - bench/tb_branch_rs.sv

// File: bench/branch_rs_checker.sv
// Concurrent assertions on the branch reservation station, bound into branch_rs.
// A held request or CDB beat may only end through a flush.
module branch_rs_checker (
    input logic                                         clk_i,
    input logic                                         rst_n_i,
    input logic                                         flush_i,
    input logic                                         bu_valid_i,
    input logic                                         bu_ready_i,
    input brs_pkg::bu_req_t                             bu_req_i,
    input logic                                         cdb_out_valid_i,
    input logic                                         cdb_ready_i,
    input brs_pkg::cdb_t                                cdb_out_i,
    input brs_pkg::slot_status_t [brs_pkg::RS_DEPTH-1:0] status_i,
    input brs_pkg::rs_entry_t    [brs_pkg::RS_DEPTH-1:0] entry_i
);

    int assert_fails = 0;   // Failed assertions so far

    // An outcome exists only for an instruction that had both operands
    for (genvar i = 0; i < brs_pkg::RS_DEPTH; i++) begin : gen_slot_chk
        assert property (@(posedge clk_i) disable iff (!rst_n_i)
            status_i[i].res_ready
                |-> (entry_i[i].issue.rs1_ready && entry_i[i].issue.rs2_ready))
            else begin
                $error("slot %0d holds an outcome with an operand still waiting", i);
                assert_fails++;
            end
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (bu_valid_i && !bu_ready_i && !flush_i) |=> (flush_i || (bu_valid_i && $stable(bu_req_i))))
        else begin
            $error("branch unit request changed while stalled");
            assert_fails++;
        end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (cdb_out_valid_i && !cdb_ready_i && !flush_i)
            |=> (flush_i || (cdb_out_valid_i && $stable(cdb_out_i))))
        else begin
            $error("CDB beat changed while stalled");
            assert_fails++;
        end

endmodule

bind branch_rs branch_rs_checker u_checker (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .flush_i (flush_i),
    .bu_valid_i (bu_valid_o), .bu_ready_i (bu_ready_i), .bu_req_i (bu_req_o),
    .cdb_out_valid_i (cdb_valid_o), .cdb_ready_i (cdb_ready_i), .cdb_out_i (cdb_o),
    .status_i (slot_status), .entry_i (slot_entry)
);

// File: bench/tb_branch_rs.sv
// Random testbench for branch_rs against an in-order queue model.
// The bench plays the branch unit and the CDB; outputs are sampled at the falling edge.
// Branch unit outcomes return in order, at most one per cycle.
module tb_branch_rs;

    logic clk_i, rst_n_i, flush_i, arb_valid_i, arb_ready_o;
    logic bu_valid_o, bu_ready_i, bu_result_valid_i, mispredict_i;
    logic cdb_valid_i, cdb_valid_o, cdb_ready_i;
    brs_pkg::issue_req_t issue_req_i;
    brs_pkg::bu_req_t    bu_req_o;
    brs_pkg::cdb_t       cdb_i, cdb_o, held_beat;

    brs_pkg::issue_req_t wait_q[$];     // Pushed and not yet sent
    brs_pkg::rob_idx_t   sent_q[$];     // Sent with the outcome still owed
    brs_pkg::cdb_t       done_q[$];     // Expected CDB beats
    logic                bu_pend[$];    // Mispredict bits the branch unit still owes

    integer seed;
    int     errors, n_req, n_beat, n_wake;
    logic   full_seen, held_valid;
    logic   push_en, stall_bu, stall_cdb, rand_flush, flush_req;   // Traffic modes set at negedge

    branch_rs UUT (
        .clk_i (clk_i), .rst_n_i (rst_n_i), .flush_i (flush_i),
        .arb_valid_i (arb_valid_i), .arb_ready_o (arb_ready_o), .issue_req_i (issue_req_i),
        .bu_valid_o (bu_valid_o), .bu_ready_i (bu_ready_i), .bu_req_o (bu_req_o),
        .bu_result_valid_i (bu_result_valid_i), .mispredict_i (mispredict_i),
        .cdb_valid_i (cdb_valid_i), .cdb_i (cdb_i),
        .cdb_valid_o (cdb_valid_o), .cdb_o (cdb_o), .cdb_ready_i (cdb_ready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic expect_eq(input string name, input logic [191:0] got, input logic [191:0] exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s expected %0h got %0h at %0t", name, exp, got, $time);
        end
    endtask

    function automatic brs_pkg::issue_req_t random_issue();
        brs_pkg::issue_req_t r;
        r.br_type     = brs_pkg::br_type_t'($random(seed));
        r.rs1_ready   = ($random(seed) & 1) != 0;     // Half the operands wait
        r.rs1_idx     = brs_pkg::rob_idx_t'($random(seed));
        r.rs1_value   = $random(seed);
        r.rs2_ready   = ($random(seed) & 1) != 0;
        r.rs2_idx     = brs_pkg::rob_idx_t'($random(seed));
        r.rs2_value   = $random(seed);
        r.imm         = brs_pkg::b_imm_t'($random(seed));
        r.pred_pc     = $random(seed);
        r.pred_target = $random(seed);
        r.pred_taken  = ($random(seed) & 1) != 0;
        r.dest_idx    = brs_pkg::rob_idx_t'($random(seed));
        return r;
    endfunction

    // Branch unit sees the operands and prediction fields of the instruction
    function automatic brs_pkg::bu_req_t expected_request(brs_pkg::issue_req_t r);
        brs_pkg::bu_req_t b;
        b.rs1_value   = r.rs1_value;
        b.rs2_value   = r.rs2_value;
        b.imm         = r.imm;
        b.pred_pc     = r.pred_pc;
        b.pred_target = r.pred_target;
        b.pred_taken  = r.pred_taken;
        b.br_type     = r.br_type;
        return b;
    endfunction

    // Inputs for the next cycle
    always @(posedge clk_i) begin
        if (rst_n_i) begin
            flush_i     <= flush_req || (rand_flush && (($random(seed) & 255) == 0));
            arb_valid_i <= push_en && (($random(seed) & 3) != 0);
            issue_req_i <= random_issue();
            bu_ready_i  <= !stall_bu && (($random(seed) & 3) != 0);
            cdb_ready_i <= !stall_cdb && (($random(seed) & 3) != 0);
            cdb_valid_i <= ($random(seed) & 1) != 0;
            cdb_i       <= {brs_pkg::rob_idx_t'($random(seed)), brs_pkg::xlen_t'($random(seed)),
                            (($random(seed) & 3) == 0)};       // Quarter are exceptions
            if (bu_pend.size() > 0 && ($random(seed) & 1)) begin
                bu_result_valid_i <= 1'b1;
                mispredict_i      <= bu_pend.pop_front();
            end else begin
                bu_result_valid_i <= 1'b0;
                mispredict_i      <= 1'b0;
            end
        end
    end

    // Check outputs and then apply the transfers of the coming edge
    task automatic step_model();
        brs_pkg::issue_req_t ent;
        brs_pkg::cdb_t       beat;
        logic                exp_arb, exp_bu, exp_cdb;
        int                  occ, i;
        occ     = wait_q.size() + sent_q.size() + done_q.size();
        exp_arb = !flush_i && (occ < brs_pkg::RS_DEPTH);   // Full stops the issue stage
        exp_bu  = 1'b0;
        if (!flush_i && wait_q.size() > 0) begin
            ent    = wait_q[0];
            exp_bu = ent.rs1_ready && ent.rs2_ready;
        end
        exp_cdb = !flush_i && (done_q.size() > 0);
        expect_eq("arb_ready_o", arb_ready_o, exp_arb);
        expect_eq("bu_valid_o", bu_valid_o, exp_bu);
        expect_eq("cdb_valid_o", cdb_valid_o, exp_cdb);
        if (exp_bu) begin
            expect_eq("bu_req_o", bu_req_o, expected_request(wait_q[0]));
        end
        if (exp_cdb) begin
            expect_eq("cdb_o", cdb_o, done_q[0]);
        end
        if (held_valid && !flush_i) begin   // Beat under back-pressure stays put
            expect_eq("cdb_valid_o", cdb_valid_o, 1'b1);
            expect_eq("cdb_o", cdb_o, held_beat);
        end
        held_valid = cdb_valid_o && !cdb_ready_i && !flush_i;
        held_beat  = cdb_o;
        if (occ == brs_pkg::RS_DEPTH && !flush_i && arb_ready_o === 1'b0) full_seen = 1'b1;
        if (flush_i) begin
            wait_q.delete();
            sent_q.delete();
            done_q.delete();
            bu_pend.delete();      // Outcomes of flushed requests never come
        end else begin
            if (exp_cdb && cdb_ready_i) begin
                void'(done_q.pop_front());
                n_beat++;
            end
            if (bu_result_valid_i) begin
                beat.rob_idx       = sent_q.pop_front();
                beat.value         = '0;
                beat.value[0]      = mispredict_i;
                beat.except_raised = 1'b0;
                done_q.push_back(beat);
            end
            if (exp_bu && bu_ready_i) begin
                ent = wait_q.pop_front();
                sent_q.push_back(ent.dest_idx);
                bu_pend.push_back(($random(seed) & 1) != 0);
                n_req++;
            end
            // Wakeup comes before the push so a same-cycle push misses the broadcast
            for (i = 0; i < wait_q.size() && cdb_valid_i && !cdb_i.except_raised; i++) begin
                ent = wait_q[i];
                if (!ent.rs1_ready && ent.rs1_idx == cdb_i.rob_idx) begin
                    ent.rs1_ready = 1'b1;
                    ent.rs1_value = cdb_i.value;
                    n_wake++;
                end
                if (!ent.rs2_ready && ent.rs2_idx == cdb_i.rob_idx) begin
                    ent.rs2_ready = 1'b1;
                    ent.rs2_value = cdb_i.value;
                    n_wake++;
                end
                wait_q[i] = ent;
            end
            if (arb_valid_i && exp_arb) wait_q.push_back(issue_req_i);
        end
    endtask

    always @(negedge clk_i) begin
        if (rst_n_i) begin
            step_model();
        end else begin
            held_valid = 1'b0;
        end
    end

    task automatic run_cycles(input int n);
        repeat (n) @(negedge clk_i);
    endtask

    task automatic wait_drained(input int limit);
        int t;
        t = 0;
        while ((wait_q.size() + sent_q.size() + done_q.size()) != 0 && t < limit) begin
            @(posedge clk_i);
            t++;
        end
        if ((wait_q.size() + sent_q.size() + done_q.size()) != 0) begin
            errors++;
            $display("timeout: station still holds entries after %0d cycles", limit);
        end
    endtask

    initial begin
        seed = 32'hadf0;
        {errors, n_req, n_beat, n_wake} = '0;
        {full_seen, held_valid, push_en, stall_bu, stall_cdb, rand_flush, flush_req} = '0;
        rst_n_i = 1'b0;
        {flush_i, arb_valid_i, bu_ready_i, bu_result_valid_i, mispredict_i} = '0;
        {cdb_valid_i, cdb_ready_i} = '0;
        issue_req_i = '0;
        cdb_i       = '0;
        repeat (16) @(posedge clk_i);
        rst_n_i <= 1'b1;
        run_cycles(1);
        push_en    = 1'b1;        // Random traffic with rare flushes
        rand_flush = 1'b1;
        run_cycles(500);
        rand_flush = 1'b0;
        stall_bu   = 1'b1;        // Station must fill up
        run_cycles(6 * brs_pkg::RS_DEPTH);
        stall_bu   = 1'b0;
        stall_cdb  = 1'b1;
        run_cycles(30);
        stall_cdb  = 1'b0;
        flush_req  = 1'b1;
        run_cycles(1);
        flush_req  = 1'b0;
        rand_flush = 1'b1;
        run_cycles(300);
        rand_flush = 1'b0;
        push_en    = 1'b0;
        wait_drained(3000);
        if (!full_seen) begin
            errors++;
            $display("station never reported full while the branch unit stalled");
        end
        if (n_wake == 0 || n_beat == 0) begin
            errors++;
            $display("no operand wakeup or no CDB beat was exercised");
        end
        errors += UUT.u_checker.assert_fails;     // Bound checker failures
        $display("errors %0d, requests %0d, cdb beats %0d, wakeups %0d",
                 errors, n_req, n_beat, n_wake);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: common/brs_pkg.sv
// Shared widths, vector types and bus structs of the branch reservation station.
// RS_DEPTH need not be a power of two; pointers wrap through next_idx().
// Field order in the structs is the bit layout seen by the bench.
package brs_pkg;

    localparam int XLEN        = 32;
    localparam int ROB_IDX_LEN = 4;
    localparam int B_IMM       = 12;
    localparam int BR_TYPE_LEN = 3;
    localparam int RS_DEPTH    = 8;
    localparam int RS_IDX_LEN  = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

    typedef logic [XLEN-1:0]        xlen_t;     // Operand or PC value
    typedef logic [ROB_IDX_LEN-1:0] rob_idx_t;  // Reorder buffer tag
    typedef logic [RS_IDX_LEN-1:0]  rs_idx_t;   // Station pointer
    typedef logic [B_IMM-1:0]       b_imm_t;
    typedef logic [BR_TYPE_LEN-1:0] br_type_t;  // Comparison code for the branch unit
    typedef logic [RS_DEPTH-1:0]    rs_mask_t;  // One-hot slot strobe

    // Instruction as delivered by the issue stage
    typedef struct packed {
        br_type_t br_type;
        logic     rs1_ready;    // rs1_value already valid
        rob_idx_t rs1_idx;      // Producer tag while not ready
        xlen_t    rs1_value;
        logic     rs2_ready;
        rob_idx_t rs2_idx;
        xlen_t    rs2_value;
        b_imm_t   imm;
        xlen_t    pred_pc;
        xlen_t    pred_target;
        logic     pred_taken;
        rob_idx_t dest_idx;     // ROB entry that receives the outcome
    } issue_req_t;

    // Request to the branch unit
    typedef struct packed {
        xlen_t    rs1_value;
        xlen_t    rs2_value;
        b_imm_t   imm;
        xlen_t    pred_pc;
        xlen_t    pred_target;
        logic     pred_taken;
        br_type_t br_type;
    } bu_req_t;

    // One common data bus beat
    typedef struct packed {
        rob_idx_t rob_idx;
        xlen_t    value;
        logic     except_raised;
    } cdb_t;

    typedef struct packed {
        logic valid;            // Slot holds an instruction
        logic busy;             // Sent to the branch unit, outcome pending
        logic exec_ready;       // Operands complete and not yet sent
        logic res_ready;        // Outcome stored, waiting for the CDB
    } slot_status_t;

    typedef struct packed {
        issue_req_t issue;
        logic       mispredicted;
    } rs_entry_t;

    // Wrapping increment of a station pointer
    function automatic rs_idx_t next_idx(rs_idx_t idx);
        if (idx == rs_idx_t'(RS_DEPTH - 1)) begin
            return '0;
        end
        return idx + rs_idx_t'(1);
    endfunction

    // Strobe for a single slot
    function automatic rs_mask_t idx_onehot(rs_idx_t idx);
        rs_mask_t mask;
        mask      = '0;
        mask[idx] = 1'b1;
        return mask;
    endfunction

endpackage

// File: logic/branch_rs.sv
// Branch reservation station top level, RS_DEPTH entries from brs_pkg.
// Plain valid/ready strobes; bu_result_valid_i is an unconditional pulse.
// Operands broadcast in the push cycle are missed by the new entry.
module branch_rs (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                arb_valid_i,
    output logic                arb_ready_o,
    input  brs_pkg::issue_req_t issue_req_i,
    output logic                bu_valid_o,
    input  logic                bu_ready_i,
    output brs_pkg::bu_req_t    bu_req_o,
    input  logic                bu_result_valid_i,
    input  logic                mispredict_i,
    input  logic                cdb_valid_i,
    input  brs_pkg::cdb_t       cdb_i,
    output logic                cdb_valid_o,
    output brs_pkg::cdb_t       cdb_o,
    input  logic                cdb_ready_i
);

    brs_pkg::slot_status_t [brs_pkg::RS_DEPTH-1:0] slot_status;
    brs_pkg::rs_entry_t    [brs_pkg::RS_DEPTH-1:0] slot_entry;
    brs_pkg::rs_mask_t                             push_mask;
    brs_pkg::rs_mask_t                             issue_mask;
    brs_pkg::rs_mask_t                             wr_res_mask;
    brs_pkg::rs_mask_t                             pop_mask;
    brs_pkg::issue_req_t                           push_req;

    brs_ctrl u_ctrl (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .flush_i           (flush_i),
        .arb_valid_i       (arb_valid_i),
        .arb_ready_o       (arb_ready_o),
        .issue_req_i       (issue_req_i),
        .push_req_o        (push_req),
        .bu_ready_i        (bu_ready_i),
        .bu_valid_o        (bu_valid_o),
        .bu_req_o          (bu_req_o),
        .bu_result_valid_i (bu_result_valid_i),
        .status_i          (slot_status),
        .entry_i           (slot_entry),
        .push_o            (push_mask),
        .issue_o           (issue_mask),
        .wr_res_o          (wr_res_mask)
    );

    for (genvar i = 0; i < brs_pkg::RS_DEPTH; i++) begin : gen_slot
        brs_slot u_slot (
            .clk_i        (clk_i),
            .rst_n_i      (rst_n_i),
            .flush_i      (flush_i),
            .push_i       (push_mask[i]),
            .issue_req_i  (push_req),
            .issue_i      (issue_mask[i]),
            .wr_res_i     (wr_res_mask[i]),
            .mispredict_i (mispredict_i),
            .pop_i        (pop_mask[i]),
            .cdb_valid_i  (cdb_valid_i),
            .cdb_i        (cdb_i),
            .status_o     (slot_status[i]),
            .entry_o      (slot_entry[i])
        );
    end

    brs_drain u_drain (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .status_i    (slot_status),
        .entry_i     (slot_entry),
        .cdb_ready_i (cdb_ready_i),
        .cdb_valid_o (cdb_valid_o),
        .cdb_o       (cdb_o),
        .pop_o       (pop_mask)
    );

endmodule

// File: logic/brs_ctrl.sv
// Push, issue and result-write control of the branch reservation station.
// Branch unit outcomes must come back in issue order, one pulse per request.
// A flush cycle blocks every transfer and clears all three pointers.
module brs_ctrl (
    input  logic                                         clk_i,
    input  logic                                         rst_n_i,
    input  logic                                         flush_i,
    input  logic                                         arb_valid_i,
    output logic                                         arb_ready_o,
    input  brs_pkg::issue_req_t                          issue_req_i,
    output brs_pkg::issue_req_t                          push_req_o,
    input  logic                                         bu_ready_i,
    output logic                                         bu_valid_o,
    output brs_pkg::bu_req_t                             bu_req_o,
    input  logic                                         bu_result_valid_i,
    input  brs_pkg::slot_status_t [brs_pkg::RS_DEPTH-1:0] status_i,
    input  brs_pkg::rs_entry_t    [brs_pkg::RS_DEPTH-1:0] entry_i,
    output brs_pkg::rs_mask_t                            push_o,
    output brs_pkg::rs_mask_t                            issue_o,
    output brs_pkg::rs_mask_t                            wr_res_o
);

    brs_pkg::rs_idx_t   tail_q;     // Next free slot
    brs_pkg::rs_idx_t   ex_q;       // Oldest slot not yet sent
    brs_pkg::rs_idx_t   wr_q;       // Oldest slot awaiting its outcome
    logic               push;
    logic               issue;
    logic               wr_res;
    brs_pkg::rs_entry_t ex_entry;

    // Full when the tail slot still holds an entry
    assign arb_ready_o = !status_i[tail_q].valid && !flush_i;
    assign push        = arb_valid_i && arb_ready_o;

    // In-order issue, only the execute slot is offered
    assign bu_valid_o  = status_i[ex_q].exec_ready && !flush_i;
    assign issue       = bu_valid_o && bu_ready_i;

    // A pulse with no busy slot is dropped
    assign wr_res      = bu_result_valid_i && status_i[wr_q].busy && !flush_i;

    assign push_o      = push   ? brs_pkg::idx_onehot(tail_q) : '0;
    assign issue_o     = issue  ? brs_pkg::idx_onehot(ex_q)   : '0;
    assign wr_res_o    = wr_res ? brs_pkg::idx_onehot(wr_q)   : '0;

    // All slots see the payload, the push strobe picks one
    assign push_req_o  = issue_req_i;

    assign ex_entry = entry_i[ex_q];

    always_comb begin
        bu_req_o.rs1_value   = ex_entry.issue.rs1_value;
        bu_req_o.rs2_value   = ex_entry.issue.rs2_value;
        bu_req_o.imm         = ex_entry.issue.imm;
        bu_req_o.pred_pc     = ex_entry.issue.pred_pc;
        bu_req_o.pred_target = ex_entry.issue.pred_target;
        bu_req_o.pred_taken  = ex_entry.issue.pred_taken;
        bu_req_o.br_type     = ex_entry.issue.br_type;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tail_q <= '0;
            ex_q   <= '0;
            wr_q   <= '0;
        end else if (flush_i) begin
            tail_q <= '0;
            ex_q   <= '0;
            wr_q   <= '0;
        end else begin
            if (push)   tail_q <= brs_pkg::next_idx(tail_q);
            if (issue)  ex_q   <= brs_pkg::next_idx(ex_q);
            if (wr_res) wr_q   <= brs_pkg::next_idx(wr_q);
        end
    end

endmodule

// File: logic/brs_drain.sv
// Writes completed branch outcomes to the CDB in push order.
// The CDB value is the mispredict bit, zero-extended; no exception is raised.
// cdb_o follows the head entry and holds while cdb_ready_i is low.
module brs_drain (
    input  logic                                         clk_i,
    input  logic                                         rst_n_i,
    input  logic                                         flush_i,
    input  brs_pkg::slot_status_t [brs_pkg::RS_DEPTH-1:0] status_i,
    input  brs_pkg::rs_entry_t    [brs_pkg::RS_DEPTH-1:0] entry_i,
    input  logic                                         cdb_ready_i,
    output logic                                         cdb_valid_o,
    output brs_pkg::cdb_t                                cdb_o,
    output brs_pkg::rs_mask_t                            pop_o
);

    brs_pkg::rs_idx_t   head_q;     // Oldest valid entry
    brs_pkg::rs_entry_t head_entry;
    logic               pop;

    assign head_entry  = entry_i[head_q];

    // Head must have its outcome before it can leave
    assign cdb_valid_o = status_i[head_q].res_ready && !flush_i;
    assign pop         = cdb_valid_o && cdb_ready_i;
    assign pop_o       = pop ? brs_pkg::idx_onehot(head_q) : '0;

    always_comb begin
        cdb_o.rob_idx       = head_entry.issue.dest_idx;
        cdb_o.value         = brs_pkg::xlen_t'(head_entry.mispredicted);
        cdb_o.except_raised = 1'b0;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q <= '0;
        end else if (flush_i) begin
            head_q <= '0;
        end else if (pop) begin
            head_q <= brs_pkg::next_idx(head_q);
        end
    end

endmodule

// File: logic/brs_slot.sv
// One entry of the branch reservation station.
// Strobes arrive one-hot from the controllers; at most one slot sees each.
// An operand broadcast in the push cycle is not captured.
module brs_slot (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 flush_i,
    input  logic                 push_i,
    input  brs_pkg::issue_req_t  issue_req_i,
    input  logic                 issue_i,
    input  logic                 wr_res_i,
    input  logic                 mispredict_i,
    input  logic                 pop_i,
    input  logic                 cdb_valid_i,
    input  brs_pkg::cdb_t        cdb_i,
    output brs_pkg::slot_status_t status_o,
    output brs_pkg::rs_entry_t   entry_o
);

    logic               valid_q;
    logic               busy_q;
    logic               res_q;
    logic [1:0]         op_rdy_q;   // bit 0 rs1, bit 1 rs2
    brs_pkg::rs_entry_t entry_q;    // Payload, no reset
    logic               cdb_hit;
    logic               snoop_rs1;
    logic               snoop_rs2;

    // A flagged broadcast never wakes an operand
    assign cdb_hit   = cdb_valid_i && !cdb_i.except_raised;
    assign snoop_rs1 = valid_q && !op_rdy_q[0] && cdb_hit
                       && (cdb_i.rob_idx == entry_q.issue.rs1_idx);
    assign snoop_rs2 = valid_q && !op_rdy_q[1] && cdb_hit
                       && (cdb_i.rob_idx == entry_q.issue.rs2_idx);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q  <= 1'b0;
            busy_q   <= 1'b0;
            res_q    <= 1'b0;
            op_rdy_q <= 2'b00;
        end else if (flush_i) begin
            valid_q  <= 1'b0;
            busy_q   <= 1'b0;
            res_q    <= 1'b0;
            op_rdy_q <= 2'b00;
        end else if (push_i) begin
            valid_q  <= 1'b1;
            busy_q   <= 1'b0;
            res_q    <= 1'b0;
            op_rdy_q <= {issue_req_i.rs2_ready, issue_req_i.rs1_ready};
        end else begin
            if (snoop_rs1) op_rdy_q[0] <= 1'b1;
            if (snoop_rs2) op_rdy_q[1] <= 1'b1;
            if (issue_i) begin
                busy_q <= 1'b1;     // Not offered again
            end
            // Result write clears busy only, payload keeps its fields
            if (wr_res_i) begin
                busy_q <= 1'b0;
                res_q  <= 1'b1;
            end
            if (pop_i) begin
                valid_q <= 1'b0;
                res_q   <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            entry_q.issue <= issue_req_i;
        end else begin
            if (snoop_rs1) entry_q.issue.rs1_value <= cdb_i.value;
            if (snoop_rs2) entry_q.issue.rs2_value <= cdb_i.value;
        end
        if (wr_res_i) begin
            entry_q.mispredicted <= mispredict_i;
        end
    end

    // Ready flags come from the reset registers, not the stored copy
    always_comb begin
        entry_o                 = entry_q;
        entry_o.issue.rs1_ready = op_rdy_q[0];
        entry_o.issue.rs2_ready = op_rdy_q[1];
    end

    assign status_o.valid      = valid_q;
    assign status_o.busy       = busy_q;
    assign status_o.exec_ready = valid_q && (&op_rdy_q) && !busy_q && !res_q;
    assign status_o.res_ready  = valid_q && res_q;

endmodule

// File: sources.f
common/brs_pkg.sv
logic/brs_slot.sv
logic/brs_ctrl.sv
logic/brs_drain.sv
logic/branch_rs.sv
bench/branch_rs_checker.sv
bench/tb_branch_rs.sv
